// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing
TOP       := tb_dcache
FILELIST  := all.f
BUILD     := obj_dir
LOG       := sim.log
PASS      := All tests passed!

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS)" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)

// ==== all.f ====
hw/dcache_pkg.sv
hw/replay_fifo.sv
hw/dcache_tag_array.sv
hw/dcache_data_array.sv
hw/dcache_ctrl.sv
hw/dcache_top.sv
dv/dcache_checker.sv
dv/tb_dcache.sv

// ==== dv/dcache_checker.sv ====
/*
 * Result and memory traffic checker for the data cache:
 * in-order result compare, reads per request, store write masks,
 * idle outputs after reset, and counts
 */
`timescale 1ns/1ns

module dcache_checker
   #( parameter int ROWS = 20
   )
   ( input  logic                          clk_i
   , input  logic                          arst_n_i
   , input  logic                          idle_i
   , input  logic                          req_ready_i
   , input  logic                          v_i
   , input  logic [dcache_pkg::DWORD_W-1:0] data_i
   , input  logic                          mem_cmd_v_i
   , input  logic                          mem_cmd_ready_i
   , input  logic                          mem_cmd_write_i
   , input  logic [dcache_pkg::BYTES_W-1:0] mem_cmd_mask_i
   , input  logic                          mem_resp_ready_i
   , input  logic [dcache_pkg::DWORD_W-1:0] exp_data_i [ROWS]
   , input  int                            exp_reads_i [ROWS]
   , input  logic [dcache_pkg::BYTES_W-1:0] exp_mask_i [ROWS]
   , output int                            results_o
   , output int                            reads_o
   , output int                            writes_o
   , output int                            errors_o
   );

   int n_res = 0;
   int n_rd = 0;
   int n_wr = 0;
   int n_err = 0;
   int since_rd = 0;

   assign results_o = n_res;
   assign reads_o   = n_rd;
   assign writes_o  = n_wr;
   assign errors_o  = n_err;

   // Sampled on the rising edge, before the DUT registers update
   always @(posedge clk_i)
   begin
      if (arst_n_i)
      begin
         if (idle_i && (v_i || mem_cmd_v_i || mem_resp_ready_i || !req_ready_i))
         begin
            $display("outputs not idle after reset at time %0t", $time);
            n_err++;
         end
         if (mem_cmd_v_i && mem_cmd_ready_i && !mem_cmd_write_i)
         begin
            n_rd++;
            since_rd++;
         end
         if (mem_cmd_v_i && mem_cmd_ready_i && mem_cmd_write_i)
         begin
            n_wr++;
            if (!v_i || n_res >= ROWS || exp_mask_i[n_res] == '0)
            begin
               $display("memory write at time %0t without a store result", $time);
               n_err++;
            end
         end
         if (v_i && n_res >= ROWS)
         begin
            $display("more results than requests at time %0t", $time);
            n_err++;
         end
         else if (v_i)
         begin
            if (data_i !== exp_data_i[n_res])
            begin
               $display("error %0t: row %0d returned %h, expected %h",
                        $time, n_res, data_i, exp_data_i[n_res]);
               n_err++;
            end
            if (since_rd != exp_reads_i[n_res])
            begin
               $display("error %0t: row %0d caused %0d memory reads, expected %0d",
                        $time, n_res, since_rd, exp_reads_i[n_res]);
               n_err++;
            end
            // Stores commit in the cycle their write is accepted
            if (exp_mask_i[n_res] != '0 && !(mem_cmd_v_i && mem_cmd_ready_i && mem_cmd_write_i))
            begin
               $display("store result of row %0d came without its memory write", n_res);
               n_err++;
            end
            else if (exp_mask_i[n_res] != '0 && mem_cmd_mask_i != exp_mask_i[n_res])
            begin
               $display("error %0t: row %0d write mask %h, expected %h",
                        $time, n_res, mem_cmd_mask_i, exp_mask_i[n_res]);
               n_err++;
            end
            n_res++;
            since_rd = 0;
         end
      end
   end

endmodule

// ==== dv/tb_dcache.sv ====
/*
 * Testbench for the data cache: clock and reset, request table,
 * sparse memory model with random latency and command back-pressure
 */
`timescale 1ns/1ns

module tb_dcache;

   import dcache_pkg::*;

   localparam int ROWS    = 20;
   localparam int TIMEOUT = 500;

   logic               clk = 1'b0;
   logic               arst_n = 1'b0;
   logic               idle = 1'b0;
   logic               req_v = 1'b0;
   logic [OP_W-1:0]    req_op = '0;
   logic [ADDR_W-1:0]  req_addr = '0;
   logic [DWORD_W-1:0] req_data = '0;
   logic               req_unc = 1'b0;
   logic               req_ready, res_v, cmd_v, cmd_write, resp_ready;
   logic [DWORD_W-1:0] res_data, cmd_data;
   logic [ADDR_W-1:0]  cmd_addr;
   logic [BYTES_W-1:0] cmd_mask;
   logic               cmd_ready = 1'b0;
   logic               resp_v = 1'b0;
   logic [DWORD_W-1:0] resp_data = '0;

   logic [OP_W-1:0]    t_op [ROWS];
   logic [ADDR_W-1:0]  t_addr [ROWS];
   logic [DWORD_W-1:0] t_data [ROWS];
   logic               t_unc [ROWS];
   logic [DWORD_W-1:0] t_exp [ROWS];
   int                 t_reads [ROWS];
   logic [BYTES_W-1:0] t_mask [ROWS];
   int                 n_rows = 0;

   dcache_dword_u      mem_q [logic [ADDR_W-1:0]];
   logic               rd_pend = 1'b0;
   logic               rd_started = 1'b0;
   logic [ADDR_W-1:0]  rd_addr = '0;
   int                 lat_cnt = 0;

   int                 results, reads, writes, errors;
   int                 tb_errors = 0;
   int                 tries;
   logic               timed_out = 1'b0;

   always #50 clk = ~clk;

   dcache_top uut
      (.clk_i(clk), .arst_n_i(arst_n)
      ,.req_v_i(req_v), .req_op_i(req_op), .req_addr_i(req_addr), .req_data_i(req_data)
      ,.req_uncached_i(req_unc), .req_ready_o(req_ready)
      ,.v_o(res_v), .data_o(res_data)
      ,.mem_cmd_v_o(cmd_v), .mem_cmd_write_o(cmd_write), .mem_cmd_addr_o(cmd_addr)
      ,.mem_cmd_data_o(cmd_data), .mem_cmd_mask_o(cmd_mask), .mem_cmd_ready_and_i(cmd_ready)
      ,.mem_resp_v_i(resp_v), .mem_resp_data_i(resp_data), .mem_resp_ready_and_o(resp_ready)
      );

   dcache_checker #(.ROWS(ROWS)) chk
      (.clk_i(clk), .arst_n_i(arst_n), .idle_i(idle), .req_ready_i(req_ready)
      ,.v_i(res_v), .data_i(res_data)
      ,.mem_cmd_v_i(cmd_v), .mem_cmd_ready_i(cmd_ready), .mem_cmd_write_i(cmd_write)
      ,.mem_cmd_mask_i(cmd_mask), .mem_resp_ready_i(resp_ready)
      ,.exp_data_i(t_exp), .exp_reads_i(t_reads), .exp_mask_i(t_mask)
      ,.results_o(results), .reads_o(reads), .writes_o(writes), .errors_o(errors)
      );

   // Never-written dword: aligned address XOR 5a5a in every quarter
   function automatic logic [DWORD_W-1:0] init_pattern(input logic [ADDR_W-1:0] addr);
      logic [15:0] q;
      q = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}} ^ 16'h5a5a;
      return {4{q}};
   endfunction

   function automatic dcache_dword_u read_mem(input logic [ADDR_W-1:0] addr);
      dcache_dword_u w;
      if (mem_q.exists(addr))
         w = mem_q[addr];
      else
         w.dword = init_pattern(addr);
      return w;
   endfunction

   task automatic add_row(input logic [OP_W-1:0] op, input logic [ADDR_W-1:0] addr,
                          input logic [DWORD_W-1:0] data, input logic unc,
                          input logic [DWORD_W-1:0] exp, input int rd,
                          input logic [BYTES_W-1:0] mask);
      t_op[n_rows]    = op;
      t_addr[n_rows]  = addr;
      t_data[n_rows]  = data;
      t_unc[n_rows]   = unc;
      t_exp[n_rows]   = exp;
      t_reads[n_rows] = rd;
      t_mask[n_rows]  = mask;
      n_rows++;
   endtask

   task automatic send_row(input int i);
      int wait_cnt;
      wait_cnt = 0;
      req_v    = 1'b1;
      req_op   = t_op[i];
      req_addr = t_addr[i];
      req_data = t_data[i];
      req_unc  = t_unc[i];
      while (!req_ready && wait_cnt < TIMEOUT)
      begin
         @(negedge clk);
         wait_cnt++;
      end
      if (!req_ready)
      begin
         $display("request of row %0d was never accepted", i);
         timed_out = 1'b1;
      end
      @(negedge clk);
      req_v = 1'b0;
   endtask

   // Memory model bookkeeping at the handshake edge
   always @(posedge clk)
   begin
      if (arst_n && cmd_v && cmd_ready && cmd_write)
      begin
         dcache_dword_u w, d;
         w = read_mem(cmd_addr);
         d.dword = cmd_data;
         for (int b = 0; b < BYTES_W; b++)
         begin
            if (cmd_mask[b])
               w.bytes[b] = d.bytes[b];
         end
         mem_q[cmd_addr] = w;
      end
      else if (arst_n && cmd_v && cmd_ready)
      begin
         rd_pend = 1'b1;
         rd_addr = cmd_addr;
      end
      if (resp_v && resp_ready)
         rd_pend = 1'b0;
   end

   // Back-pressure and read responses on the falling edge
   always @(negedge clk)
   begin
      cmd_ready = ($urandom % 4) != 0;
      if (!rd_pend)
      begin
         rd_started = 1'b0;
         resp_v     = 1'b0;
      end
      else if (!rd_started)
      begin
         rd_started = 1'b1;
         lat_cnt    = 1 + ($urandom % 6);
      end
      else if (lat_cnt > 1)
         lat_cnt--;
      else
      begin
         resp_v    = 1'b1;
         resp_data = read_mem(rd_addr);
      end
   end

   initial
   begin
      void'($urandom(32'h8362_ea94));
      // op, address, store data, uncached, expected result, memory reads, write mask
      add_row(OP_LD,  16'h0040, 64'h0, 1'b0, 64'h5a1a_5a1a_5a1a_5a1a, 1, 8'h00);
      add_row(OP_LD,  16'h0040, 64'h0, 1'b0, 64'h5a1a_5a1a_5a1a_5a1a, 0, 8'h00);
      add_row(OP_LBU, 16'h0043, 64'h0, 1'b0, 64'h5a, 0, 8'h00);
      add_row(OP_SD,  16'h0048, 64'h0123_4567_89ab_cdef, 1'b0, 64'h0, 0, 8'hff);
      add_row(OP_SB,  16'h004d, 64'hc3, 1'b0, 64'h0, 0, 8'h20);
      add_row(OP_LD,  16'h0048, 64'h0, 1'b0, 64'h0123_c367_89ab_cdef, 1, 8'h00);
      add_row(OP_LBU, 16'h004d, 64'h0, 1'b0, 64'hc3, 0, 8'h00);
      add_row(OP_SB,  16'h0040, 64'h77, 1'b0, 64'h0, 0, 8'h01);
      add_row(OP_LD,  16'h0040, 64'h0, 1'b0, 64'h5a1a_5a1a_5a1a_5a77, 0, 8'h00);
      add_row(OP_LD,  16'h0100, 64'h0, 1'b1, 64'h5b5a_5b5a_5b5a_5b5a, 1, 8'h00);
      add_row(OP_LD,  16'h0100, 64'h0, 1'b0, 64'h5b5a_5b5a_5b5a_5b5a, 1, 8'h00);
      add_row(OP_LD,  16'h0100, 64'h0, 1'b0, 64'h5b5a_5b5a_5b5a_5b5a, 0, 8'h00);
      add_row(OP_LD,  16'h0180, 64'h0, 1'b0, 64'h5bda_5bda_5bda_5bda, 1, 8'h00);
      add_row(OP_LD,  16'h0100, 64'h0, 1'b0, 64'h5b5a_5b5a_5b5a_5b5a, 1, 8'h00);
      add_row(OP_SD,  16'h0040, 64'hfeed_face_cafe_beef, 1'b0, 64'h0, 0, 8'hff);
      add_row(OP_LBU, 16'h0046, 64'h0, 1'b0, 64'hed, 0, 8'h00);
      add_row(OP_SB,  16'h0102, 64'h3c, 1'b0, 64'h0, 0, 8'h04);
      add_row(OP_LD,  16'h0100, 64'h0, 1'b0, 64'h5b5a_5b5a_5b3c_5b5a, 0, 8'h00);
      add_row(OP_LD,  16'h0048, 64'h0, 1'b1, 64'h0123_c367_89ab_cdef, 1, 8'h00);
      add_row(OP_LBU, 16'h07f9, 64'h0, 1'b0, 64'h5d, 1, 8'h00);

      repeat (2) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
      idle   = 1'b1;
      repeat (4) @(negedge clk);
      idle = 1'b0;

      for (int i = 0; i < n_rows && !timed_out; i++)
         send_row(i);

      tries = 0;
      while (!timed_out && results < n_rows && tries < TIMEOUT)
      begin
         @(negedge clk);
         tries++;
      end
      if (results != n_rows)
      begin
         $display("got %0d results for %0d requests", results, n_rows);
         tb_errors++;
      end

      $display("results %0d of %0d, memory reads %0d, memory writes %0d, errors %0d",
               results, n_rows, reads, writes, errors + tb_errors);
      if (errors == 0 && tb_errors == 0 && !timed_out)
         $display("All tests passed!");
      else
         $display("Test failures found");
      $finish;
   end

endmodule

// ==== hw/dcache_ctrl.sv ====
/*
 * Cache controller: two-stage issue pipeline, hit decision,
 * result mux, write-through stores, store forwarding,
 * miss and uncached read engine, commit and rollback
 */
`timescale 1ns/1ns

module dcache_ctrl
   ( input  logic                          clk_i
   , input  logic                          arst_n_i
   , input  logic                          head_v_i
   , input  logic [dcache_pkg::PKT_W-1:0]   head_data_i
   , output logic                          issue_yumi_o
   , output logic                          commit_o
   , output logic                          roll_o
   , output logic [dcache_pkg::INDEX_W-1:0] lookup_index_o
   , output logic                          fill_v_o
   , output logic [dcache_pkg::TAG_W-1:0]   fill_tag_o
   , output logic                          store_v_o
   , output logic [dcache_pkg::INDEX_W-1:0] write_index_o
   , output dcache_pkg::dcache_dword_u      write_data_o
   , output logic [dcache_pkg::BYTES_W-1:0] write_mask_o
   , input  logic [dcache_pkg::TAG_W-1:0]   tag_i
   , input  logic                          valid_i
   , input  dcache_pkg::dcache_dword_u      line_i
   , output logic                          v_o
   , output logic [dcache_pkg::DWORD_W-1:0] data_o
   , output logic                          mem_cmd_v_o
   , output logic                          mem_cmd_write_o
   , output logic [dcache_pkg::ADDR_W-1:0]  mem_cmd_addr_o
   , output logic [dcache_pkg::DWORD_W-1:0] mem_cmd_data_o
   , output logic [dcache_pkg::BYTES_W-1:0] mem_cmd_mask_o
   , input  logic                          mem_cmd_ready_and_i
   , input  logic                          mem_resp_v_i
   , input  logic [dcache_pkg::DWORD_W-1:0] mem_resp_data_i
   , output logic                          mem_resp_ready_and_o
   );

   import dcache_pkg::*;

   logic [OP_W-1:0]    head_op;
   logic [ADDR_W-1:0]  head_addr;
   logic [DWORD_W-1:0] head_data;
   logic               head_unc;

   logic               s1_v_r, s1_unc_r;
   logic [OP_W-1:0]    s1_op_r;
   logic [ADDR_W-1:0]  s1_addr_r;
   logic [DWORD_W-1:0] s1_data_r;

   logic               s2_v_r, s2_unc_r, s2_valid_r;
   logic [OP_W-1:0]    s2_op_r;
   logic [ADDR_W-1:0]  s2_addr_r;
   logic [DWORD_W-1:0] s2_data_r;
   logic [TAG_W-1:0]   s2_tag_r;
   dcache_dword_u      s2_line_r;

   logic [1:0]         state_r;
   logic [OP_W-1:0]    miss_op_r;
   logic [ADDR_W-1:0]  miss_addr_r;
   logic               miss_unc_r, ret_r;
   dcache_dword_u      resp_r;

   logic               run, s2_act, s2_store, s1_unc_ld, s2_unc_ld;
   logic               tag_hit, ld_hit, ld_go_mem, st_done, resp_hs;
   logic [BYTES_W-1:0] st_mask;
   logic [ADDR_W-1:0]  cmd_addr;
   logic [OP_W-1:0]    res_op;
   logic [OFFSET_W-1:0] res_off;
   dcache_dword_u      st_word, fwd_line, res_word;

   assign {head_op, head_addr, head_data, head_unc} = head_data_i;
   assign lookup_index_o = head_addr[INDEX_LSB +: INDEX_W];

   // Decision stage
   assign run       = (state_r == ST_RUN);
   assign s2_act    = run & s2_v_r;
   assign s2_store  = (s2_op_r == OP_SD) || (s2_op_r == OP_SB);
   assign tag_hit   = s2_valid_r && (s2_tag_r == s2_addr_r[TAG_LSB +: TAG_W]);
   assign ld_hit    = s2_act & ~s2_store & ~s2_unc_r & tag_hit;
   assign ld_go_mem = s2_act & ~s2_store & (s2_unc_r | ~tag_hit);
   assign st_done   = s2_act & s2_store & mem_cmd_ready_and_i;
   assign roll_o    = s2_act & ((~s2_store & ~s2_unc_r & ~tag_hit)
                              | (s2_store & ~mem_cmd_ready_and_i));

   assign v_o      = ld_hit | st_done | ret_r;
   assign commit_o = v_o;

   // Nothing younger may follow an uncached load
   assign s1_unc_ld    = s1_v_r && s1_unc_r && (s1_op_r == OP_LD || s1_op_r == OP_LBU);
   assign s2_unc_ld    = s2_v_r && s2_unc_r && !s2_store;
   assign issue_yumi_o = head_v_i & run & ~roll_o & ~s1_unc_ld & ~s2_unc_ld;

   // Store byte goes out on every lane
   always_comb
   begin
      if (s2_op_r == OP_SB)
      begin
         st_word.dword = {BYTES_W{s2_data_r[7:0]}};
         st_mask       = BYTES_W'(1) << s2_addr_r[OFFSET_W-1:0];
      end
      else
      begin
         st_word.dword = s2_data_r;
         st_mask       = '1;
      end
   end

   assign cmd_addr             = run ? s2_addr_r : miss_addr_r;
   assign mem_cmd_v_o          = (s2_act & s2_store) | (state_r == ST_CMD);
   assign mem_cmd_write_o      = run;
   assign mem_cmd_addr_o       = {cmd_addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
   assign mem_cmd_data_o       = st_word.dword;
   assign mem_cmd_mask_o       = st_mask;
   assign mem_resp_ready_and_o = (state_r == ST_WAIT);
   assign resp_hs              = mem_resp_v_i & mem_resp_ready_and_o;

   assign fill_v_o      = resp_hs & ~miss_unc_r;
   assign fill_tag_o    = miss_addr_r[TAG_LSB +: TAG_W];
   assign store_v_o     = st_done & tag_hit;
   assign write_index_o = fill_v_o ? miss_addr_r[INDEX_LSB +: INDEX_W]
                                   : s2_addr_r[INDEX_LSB +: INDEX_W];
   assign write_data_o  = fill_v_o ? dcache_dword_u'(mem_resp_data_i) : st_word;
   assign write_mask_o  = fill_v_o ? {BYTES_W{1'b1}} : st_mask;

   // Younger op in stage 1 read the line before this store
   always_comb
   begin
      fwd_line = line_i;
      if (store_v_o && (s1_addr_r[INDEX_LSB +: INDEX_W] == s2_addr_r[INDEX_LSB +: INDEX_W]))
      begin
         for (int b = 0; b < BYTES_W; b++)
         begin
            if (st_mask[b])
               fwd_line.bytes[b] = st_word.bytes[b];
         end
      end
   end

   assign res_word = ret_r ? resp_r : s2_line_r;
   assign res_op   = ret_r ? miss_op_r : s2_op_r;
   assign res_off  = ret_r ? miss_addr_r[OFFSET_W-1:0] : s2_addr_r[OFFSET_W-1:0];

   always_comb
   begin
      case (res_op)
         OP_LD:   data_o = res_word.dword;
         OP_LBU:  data_o = DWORD_W'(res_word.bytes[res_off]);
         default: data_o = '0;
      endcase
   end

   always_ff @(posedge clk_i)
   begin
      if (issue_yumi_o)
         {s1_op_r, s1_addr_r, s1_data_r, s1_unc_r} <= {head_op, head_addr, head_data, head_unc};
      {s2_op_r, s2_addr_r, s2_data_r, s2_unc_r} <= {s1_op_r, s1_addr_r, s1_data_r, s1_unc_r};
      s2_tag_r   <= tag_i;
      s2_valid_r <= valid_i;
      s2_line_r  <= fwd_line;
      if (ld_go_mem)
         {miss_op_r, miss_addr_r, miss_unc_r} <= {s2_op_r, s2_addr_r, s2_unc_r};
      if (resp_hs)
         resp_r.dword <= mem_resp_data_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         s1_v_r  <= 1'b0;
         s2_v_r  <= 1'b0;
         ret_r   <= 1'b0;
         state_r <= ST_RUN;
      end
      else
      begin
         s1_v_r <= issue_yumi_o;
         s2_v_r <= s1_v_r & ~roll_o;
         ret_r  <= resp_hs & miss_unc_r;
         case (state_r)
            ST_RUN:  if (ld_go_mem) state_r <= ST_CMD;
            ST_CMD:  if (mem_cmd_ready_and_i) state_r <= ST_WAIT;
            ST_WAIT: if (mem_resp_v_i) state_r <= ST_RUN;
            default: state_r <= ST_RUN;
         endcase
      end
   end

   a_resp_when_waiting: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      mem_resp_v_i |-> (state_r == ST_WAIT))
      else $error("memory response while no read outstanding");

   a_roll_xor_commit: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      !(roll_o && commit_o))
      else $error("roll and commit in the same cycle");

endmodule

// ==== hw/dcache_data_array.sv ====
/*
 * One dword per set with registered read,
 * byte-masked store merge and whole-line fill
 */
`timescale 1ns/1ns

module dcache_data_array
   ( input  logic                          clk_i
   , input  logic                          arst_n_i
   , input  logic [dcache_pkg::INDEX_W-1:0] lookup_index_i
   , output dcache_pkg::dcache_dword_u      data_o
   , input  logic                          fill_v_i
   , input  logic                          store_v_i
   , input  logic [dcache_pkg::INDEX_W-1:0] write_index_i
   , input  dcache_pkg::dcache_dword_u      write_data_i
   , input  logic [dcache_pkg::BYTES_W-1:0] write_mask_i
   );

   import dcache_pkg::*;

   dcache_dword_u        mem_r [SETS];
   logic [BYTES_W-1:0]   eff_mask;
   logic                 bypass;

   assign eff_mask = (fill_v_i || store_v_i) ? (write_mask_i | {BYTES_W{fill_v_i}}) : '0;
   assign bypass   = (write_index_i == lookup_index_i);

   always_ff @(posedge clk_i)
   begin
      for (int b = 0; b < BYTES_W; b++)
      begin
         if (eff_mask[b])
            mem_r[write_index_i].bytes[b] <= write_data_i.bytes[b];
      end
   end

   // Read returns bytes written in the same cycle
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
         data_o <= '0;
      else
      begin
         for (int b = 0; b < BYTES_W; b++)
         begin
            if (bypass && eff_mask[b])
               data_o.bytes[b] <= write_data_i.bytes[b];
            else
               data_o.bytes[b] <= mem_r[lookup_index_i].bytes[b];
         end
      end
   end

endmodule

// ==== hw/dcache_pkg.sv ====
/*
 * Shared definitions for the write-through data cache:
 * widths, address field positions, opcodes, controller states
 * and the dword union seen as one word or as eight bytes
 */

package dcache_pkg;

   localparam int ADDR_W   = 16;
   localparam int DWORD_W  = 64;
   localparam int BYTES_W  = 8;

   // Direct-mapped, one dword per line
   localparam int SETS       = 16;
   localparam int INDEX_W    = 4;
   localparam int TAG_W      = 9;
   localparam int OFFSET_W   = 3;
   localparam int INDEX_LSB  = OFFSET_W;
   localparam int TAG_LSB    = OFFSET_W + INDEX_W;

   localparam int OP_W = 2;
   localparam logic [OP_W-1:0] OP_LD  = 2'd0;
   localparam logic [OP_W-1:0] OP_LBU = 2'd1;
   localparam logic [OP_W-1:0] OP_SD  = 2'd2;
   localparam logic [OP_W-1:0] OP_SB  = 2'd3;

   // Queue entry is {opcode, address, store data, uncached}
   localparam int PKT_W        = OP_W + ADDR_W + DWORD_W + 1;
   localparam int REPLAY_DEPTH = 8;
   localparam int REPLAY_PTR_W = 3;

   localparam logic [1:0] ST_RUN  = 2'd0;
   localparam logic [1:0] ST_CMD  = 2'd1;
   localparam logic [1:0] ST_WAIT = 2'd2;

   typedef union packed
   {
      logic [DWORD_W-1:0]          dword;
      logic [BYTES_W-1:0][7:0]     bytes;
   } dcache_dword_u;

endpackage

// ==== hw/dcache_tag_array.sv ====
/*
 * Valid bits and tags, one per set,
 * registered lookup with fill bypass
 */
`timescale 1ns/1ns

module dcache_tag_array
   ( input  logic                          clk_i
   , input  logic                          arst_n_i
   , input  logic [dcache_pkg::INDEX_W-1:0] lookup_index_i
   , output logic [dcache_pkg::TAG_W-1:0]   tag_o
   , output logic                          valid_o
   , input  logic                          fill_v_i
   , input  logic [dcache_pkg::INDEX_W-1:0] fill_index_i
   , input  logic [dcache_pkg::TAG_W-1:0]   fill_tag_i
   );

   import dcache_pkg::*;

   logic [SETS-1:0]  valid_r;
   logic [TAG_W-1:0] tag_r [SETS];
   logic             fill_hit;

   // Lookup sees a fill to the same set in the same cycle
   assign fill_hit = fill_v_i && (fill_index_i == lookup_index_i);

   always_ff @(posedge clk_i)
   begin
      if (fill_v_i)
         tag_r[fill_index_i] <= fill_tag_i;
      tag_o <= fill_hit ? fill_tag_i : tag_r[lookup_index_i];
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         valid_r <= '0;
         valid_o <= 1'b0;
      end
      else
      begin
         if (fill_v_i)
            valid_r[fill_index_i] <= 1'b1;
         valid_o <= fill_hit | valid_r[lookup_index_i];
      end
   end

endmodule

// ==== hw/dcache_top.sv ====
/*
 * Data cache top level: replay queue, tag and data
 * arrays side by side, and the controller
 */
`timescale 1ns/1ns

module dcache_top
   ( input  logic                          clk_i
   , input  logic                          arst_n_i
   , input  logic                          req_v_i
   , input  logic [dcache_pkg::OP_W-1:0]    req_op_i
   , input  logic [dcache_pkg::ADDR_W-1:0]  req_addr_i
   , input  logic [dcache_pkg::DWORD_W-1:0] req_data_i
   , input  logic                          req_uncached_i
   , output logic                          req_ready_o
   , output logic                          v_o
   , output logic [dcache_pkg::DWORD_W-1:0] data_o
   , output logic                          mem_cmd_v_o
   , output logic                          mem_cmd_write_o
   , output logic [dcache_pkg::ADDR_W-1:0]  mem_cmd_addr_o
   , output logic [dcache_pkg::DWORD_W-1:0] mem_cmd_data_o
   , output logic [dcache_pkg::BYTES_W-1:0] mem_cmd_mask_o
   , input  logic                          mem_cmd_ready_and_i
   , input  logic                          mem_resp_v_i
   , input  logic [dcache_pkg::DWORD_W-1:0] mem_resp_data_i
   , output logic                          mem_resp_ready_and_o
   );

   import dcache_pkg::*;

   logic               head_v, issue_yumi, commit, roll;
   logic [PKT_W-1:0]   head_data;
   logic [INDEX_W-1:0] lookup_index, write_index;
   logic               fill_v, store_v, tag_valid;
   logic [TAG_W-1:0]   fill_tag, tag;
   logic [BYTES_W-1:0] write_mask;
   dcache_dword_u      write_data, line;

   replay_fifo replay
      (.clk_i(clk_i), .arst_n_i(arst_n_i)
      ,.wr_v_i(req_v_i), .wr_data_i({req_op_i, req_addr_i, req_data_i, req_uncached_i})
      ,.wr_ready_o(req_ready_o)
      ,.rd_v_o(head_v), .rd_data_o(head_data), .rd_yumi_i(issue_yumi)
      ,.commit_i(commit), .roll_i(roll)
      );

   dcache_tag_array tags
      (.clk_i(clk_i), .arst_n_i(arst_n_i), .lookup_index_i(lookup_index)
      ,.tag_o(tag), .valid_o(tag_valid)
      ,.fill_v_i(fill_v), .fill_index_i(write_index), .fill_tag_i(fill_tag)
      );

   dcache_data_array data
      (.clk_i(clk_i), .arst_n_i(arst_n_i), .lookup_index_i(lookup_index), .data_o(line)
      ,.fill_v_i(fill_v), .store_v_i(store_v), .write_index_i(write_index)
      ,.write_data_i(write_data), .write_mask_i(write_mask)
      );

   dcache_ctrl ctrl
      (.clk_i(clk_i), .arst_n_i(arst_n_i)
      ,.head_v_i(head_v), .head_data_i(head_data)
      ,.issue_yumi_o(issue_yumi), .commit_o(commit), .roll_o(roll)
      ,.lookup_index_o(lookup_index), .fill_v_o(fill_v), .fill_tag_o(fill_tag)
      ,.store_v_o(store_v), .write_index_o(write_index)
      ,.write_data_o(write_data), .write_mask_o(write_mask)
      ,.tag_i(tag), .valid_i(tag_valid), .line_i(line)
      ,.v_o(v_o), .data_o(data_o)
      ,.mem_cmd_v_o(mem_cmd_v_o), .mem_cmd_write_o(mem_cmd_write_o)
      ,.mem_cmd_addr_o(mem_cmd_addr_o), .mem_cmd_data_o(mem_cmd_data_o)
      ,.mem_cmd_mask_o(mem_cmd_mask_o), .mem_cmd_ready_and_i(mem_cmd_ready_and_i)
      ,.mem_resp_v_i(mem_resp_v_i), .mem_resp_data_i(mem_resp_data_i)
      ,.mem_resp_ready_and_o(mem_resp_ready_and_o)
      );

endmodule

// ==== hw/replay_fifo.sv ====
/*
 * Request queue in front of the cache, with separate read,
 * commit and write pointers; roll returns the read pointer
 * to the oldest uncommitted entry
 */
`timescale 1ns/1ns

module replay_fifo
   ( input  logic                        clk_i
   , input  logic                        arst_n_i
   , input  logic                        wr_v_i
   , input  logic [dcache_pkg::PKT_W-1:0] wr_data_i
   , output logic                        wr_ready_o
   , output logic                        rd_v_o
   , output logic [dcache_pkg::PKT_W-1:0] rd_data_o
   , input  logic                        rd_yumi_i
   , input  logic                        commit_i
   , input  logic                        roll_i
   );

   import dcache_pkg::*;

   // Extra MSB tells full from empty
   logic [REPLAY_PTR_W:0] wptr_r, rptr_r, cptr_r;
   logic [REPLAY_PTR_W:0] used;
   logic [PKT_W-1:0]      mem_r [REPLAY_DEPTH];

   // Space counts only committed entries
   assign used       = wptr_r - cptr_r;
   assign wr_ready_o = (used != REPLAY_DEPTH);
   assign rd_v_o     = (rptr_r != wptr_r);
   assign rd_data_o  = mem_r[rptr_r[REPLAY_PTR_W-1:0]];

   always_ff @(posedge clk_i)
   begin
      if (wr_v_i && wr_ready_o)
         mem_r[wptr_r[REPLAY_PTR_W-1:0]] <= wr_data_i;
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wptr_r <= '0;
         rptr_r <= '0;
         cptr_r <= '0;
      end
      else
      begin
         if (wr_v_i && wr_ready_o)
            wptr_r <= wptr_r + 1'b1;
         if (commit_i)
            cptr_r <= cptr_r + 1'b1;
         if (roll_i)
            rptr_r <= cptr_r;
         else if (rd_yumi_i)
            rptr_r <= rptr_r + 1'b1;
      end
   end

   a_no_overfill: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      used <= REPLAY_DEPTH)
      else $error("replay queue holds more than its depth");

   a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      rd_yumi_i |-> rd_v_o)
      else $error("controller popped an empty queue");

   a_commit_issued: assert property (@(posedge clk_i) disable iff (!arst_n_i)
      commit_i |-> (cptr_r != rptr_r))
      else $error("commit without an issued entry");

endmodule
